// ==== hdl/prog_defs.svh ====
// ~~~~~~~~~~~~~~~~~~~~
// Boot programmer constants shared by packages and RTL
// ICCM depth is 2**PROG_AW words of 32 bits
// ~~~~~~~~~~~~~~~~~~~~

`ifndef PROG_DEFS_SVH
`define PROG_DEFS_SVH

// ICCM word address width
`define PROG_AW 13

// Command bytes, first byte of a session
`define PROG_CMD_ICCM  8'hB1
`define PROG_CMD_FLASH 8'hB2
`define PROG_CMD_QSPI  8'hB3

// Terminates ICCM and flash sessions
`define PROG_END_WORD 32'h00FF_FF00

`endif

// ==== hdl/prog_link_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// Serial link side types
// Command codes come from prog_defs.svh
// ~~~~~~~~~~~~~~~~~~~~

`include "prog_defs.svh"

package prog_link_pkg;

  // One received serial byte
  typedef logic [7:0] prog_byte_t;

  typedef enum logic [7:0] {
    CMD_ICCM  = `PROG_CMD_ICCM,
    CMD_FLASH = `PROG_CMD_FLASH,
    CMD_QSPI  = `PROG_CMD_QSPI
  } prog_cmd_e;

  // Controller states, WRITE is the single ICCM write cycle
  typedef enum logic [2:0] {
    PROG_IDLE  = 3'd0,
    PROG_ICCM  = 3'd1,
    PROG_FLASH = 3'd2,
    PROG_QSPI  = 3'd3,
    PROG_WRITE = 3'd4
  } prog_state_e;

endpackage

// ==== hdl/prog_mem_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// Memory side types
// Address width follows PROG_AW
// ~~~~~~~~~~~~~~~~~~~~

`include "prog_defs.svh"

package prog_mem_pkg;

  // ICCM write request, 45 bits with the default width
  typedef struct packed {
    logic [`PROG_AW-1:0] addr;
    logic [31:0]         data;
  } iccm_wr_t;

  // Config word for the quad-SPI controller
  typedef logic [31:0] qspi_cfg_t;

endpackage

// ==== hdl/spi_byte_rx.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// Serial byte receiver, LSB first, one byte per csb frame
// Pins are oversampled by clk_i: sck high and low phases
// must each last at least 3 clk_i cycles
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

module spi_byte_rx
  import prog_link_pkg::*;
(
  input  logic       clk_i,
  input  logic       por_ni,
  input  logic       sck_i,
  input  logic       sdi_i,
  input  logic       csb_i,
  output logic [7:0] byte_o,
  output logic       byte_valid_o
);

  logic [1:0] sck_sync_q;
  logic [1:0] sdi_sync_q;
  logic [1:0] csb_sync_q;
  logic       sck_d_q;
  logic       csb_d_q;
  logic       sck_rise;
  logic       csb_rise;
  logic       valid_q;
  prog_byte_t shift_q;

  // Edges seen on the synchronized pins
  assign sck_rise = sck_sync_q[1] & ~sck_d_q;
  assign csb_rise = csb_sync_q[1] & ~csb_d_q;

  // csb idles high so no frame is seen out of reset
  always_ff @(posedge clk_i or negedge por_ni) begin
    if (!por_ni) begin
      sck_sync_q <= 2'b00;
      sdi_sync_q <= 2'b00;
      csb_sync_q <= 2'b11;
      sck_d_q    <= 1'b0;
      csb_d_q    <= 1'b1;
      valid_q    <= 1'b0;
    end else begin
      sck_sync_q <= {sck_sync_q[0], sck_i};
      sdi_sync_q <= {sdi_sync_q[0], sdi_i};
      csb_sync_q <= {csb_sync_q[0], csb_i};
      sck_d_q    <= sck_sync_q[1];
      csb_d_q    <= csb_sync_q[1];
      valid_q    <= csb_rise;
    end
  end

  // LSB first, so new bits enter at the top
  always_ff @(posedge clk_i) begin
    if (sck_rise && !csb_sync_q[1]) begin
      shift_q <= {sdi_sync_q[1], shift_q[7:1]};
    end
  end

  assign byte_o       = shift_q;
  assign byte_valid_o = valid_q;

  a_valid_single : assert property (
    @(posedge clk_i) disable iff (!por_ni)
    byte_valid_o |=> !byte_valid_o
  );

endmodule

// ==== hdl/boot_prog_ctrl.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// Boot command decoder and word assembler
// Bytes arrive without back-pressure, frame gap >= 4 clk_i cycles
// Unknown command bytes are dropped in idle
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

`include "prog_defs.svh"

module boot_prog_ctrl
  import prog_link_pkg::*;
  import prog_mem_pkg::*;
(
  input  logic       clk_i,
  input  logic       por_ni,
  input  logic [7:0] byte_i,
  input  logic       byte_valid_i,
  output iccm_wr_t   iccm_wr_o,
  output logic       iccm_we_o,
  output qspi_cfg_t  q_wdata_o,
  output logic       q_valid_o,
  output logic       prog_done_o,
  output logic       reset_req_o,
  output logic       flash_intf_o,
  output logic       target_mem_o
);

  prog_state_e         state_q;
  logic [1:0]          byte_cnt_q;
  logic [31:0]         word_q;
  logic [31:0]         word_next;
  logic                word_full;
  logic                word_end;
  logic [`PROG_AW-1:0] addr_q;
  qspi_cfg_t           q_wdata_q;
  logic                q_valid_q;
  logic                prog_done_q;
  logic                reset_req_q;
  logic                flash_intf_q;
  logic                target_mem_q;

  // First byte lands in the low byte of the word
  assign word_next = {byte_i, word_q[31:8]};
  assign word_full = byte_valid_i && (byte_cnt_q == 2'd3);
  assign word_end  = word_full && (word_next == `PROG_END_WORD);

  always_ff @(posedge clk_i or negedge por_ni) begin
    if (!por_ni) begin
      state_q      <= PROG_IDLE;
      byte_cnt_q   <= 2'd0;
      addr_q       <= '0;
      q_valid_q    <= 1'b0;
      prog_done_q  <= 1'b1;
      reset_req_q  <= 1'b0;
      flash_intf_q <= 1'b0;
      target_mem_q <= 1'b1;
    end else begin
      q_valid_q <= (state_q == PROG_QSPI) && word_full;
      case (state_q)
        PROG_IDLE: begin
          if (byte_valid_i) begin
            byte_cnt_q <= 2'd0;
            case (prog_cmd_e'(byte_i))
              CMD_ICCM: begin
                state_q     <= PROG_ICCM;
                addr_q      <= '0;
                reset_req_q <= 1'b1;
                prog_done_q <= 1'b0;
              end
              CMD_FLASH: begin
                state_q      <= PROG_FLASH;
                reset_req_q  <= 1'b1;
                prog_done_q  <= 1'b0;
                flash_intf_q <= 1'b1;
              end
              CMD_QSPI: begin
                state_q <= PROG_QSPI;
              end
              default: begin
                state_q <= PROG_IDLE;
              end
            endcase
          end
        end
        PROG_ICCM: begin
          if (byte_valid_i) begin
            byte_cnt_q <= byte_cnt_q + 2'd1;
          end
          if (word_end) begin
            state_q      <= PROG_IDLE;
            reset_req_q  <= 1'b0;
            prog_done_q  <= 1'b1;
            target_mem_q <= 1'b0;
          end else if (word_full) begin
            state_q <= PROG_WRITE;
          end
        end
        // Address moves on once the write has gone out
        PROG_WRITE: begin
          addr_q  <= addr_q + 1'b1;
          state_q <= PROG_ICCM;
        end
        // Words are only watched for the end marker
        PROG_FLASH: begin
          if (byte_valid_i) begin
            byte_cnt_q <= byte_cnt_q + 2'd1;
          end
          if (word_end) begin
            state_q      <= PROG_IDLE;
            reset_req_q  <= 1'b0;
            flash_intf_q <= 1'b0;
            prog_done_q  <= 1'b1;
            target_mem_q <= 1'b1;
          end
        end
        PROG_QSPI: begin
          if (byte_valid_i) begin
            byte_cnt_q <= byte_cnt_q + 2'd1;
          end
          if (word_full) begin
            state_q <= PROG_IDLE;
          end
        end
        default: begin
          state_q <= PROG_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (byte_valid_i) begin
      word_q <= word_next;
    end
    if ((state_q == PROG_QSPI) && word_full) begin
      q_wdata_q <= word_next;
    end
  end

  // Word and address are stable for the whole write cycle
  assign iccm_wr_o    = '{addr: addr_q, data: word_q};
  assign iccm_we_o    = (state_q == PROG_WRITE);
  assign q_wdata_o    = q_wdata_q;
  assign q_valid_o    = q_valid_q;
  assign prog_done_o  = prog_done_q;
  assign reset_req_o  = reset_req_q;
  assign flash_intf_o = flash_intf_q;
  assign target_mem_o = target_mem_q;

  a_we_qvalid_excl : assert property (
    @(posedge clk_i) disable iff (!por_ni)
    !(iccm_we_o && q_valid_o)
  );

  a_flash_in_reset : assert property (
    @(posedge clk_i) disable iff (!por_ni)
    flash_intf_o |-> reset_req_o
  );

endmodule

// ==== hdl/iccm_ram.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// ICCM model, 2**PROG_AW words of 32 bits
// Synchronous write, combinational read, no reset
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

`include "prog_defs.svh"

module iccm_ram
  import prog_mem_pkg::*;
(
  input  logic                clk_i,
  input  logic                we_i,
  input  iccm_wr_t            wr_i,
  input  logic [`PROG_AW-1:0] rd_addr_i,
  output logic [31:0]         rd_data_o
);

  localparam int unsigned Depth = 2 ** `PROG_AW;

  logic [31:0] mem_q [Depth];

  always_ff @(posedge clk_i) begin
    if (we_i) begin
      mem_q[wr_i.addr] <= wr_i.data;
    end
  end

  // New data shows up the cycle after the write
  assign rd_data_o = mem_q[rd_addr_i];

  a_wr_known : assert property (
    @(posedge clk_i)
    we_i |-> !$isunknown(wr_i)
  );

endmodule

// ==== hdl/boot_prog_top.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// Serial boot programmer top, single clock domain
// QSPI, flash and CPU reset logic sit outside this block
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

`include "prog_defs.svh"

module boot_prog_top
  import prog_mem_pkg::*;
(
  input  logic                clk_i,
  input  logic                por_ni,
  input  logic                sck_i,
  input  logic                sdi_i,
  input  logic                csb_i,
  input  logic [`PROG_AW-1:0] rd_addr_i,
  output logic [31:0]         rd_data_o,
  output logic [31:0]         q_wdata_o,
  output logic                q_valid_o,
  output logic                prog_done_o,
  output logic                reset_req_o,
  output logic                flash_intf_o,
  output logic                target_mem_o
);

  logic [7:0] rx_byte;
  logic       rx_valid;
  iccm_wr_t   iccm_wr;
  logic       iccm_we;

  spi_byte_rx spi_byte_rx_i (
    .clk_i        (clk_i),
    .por_ni       (por_ni),
    .sck_i        (sck_i),
    .sdi_i        (sdi_i),
    .csb_i        (csb_i),
    .byte_o       (rx_byte),
    .byte_valid_o (rx_valid)
  );

  boot_prog_ctrl boot_prog_ctrl_i (
    .clk_i        (clk_i),
    .por_ni       (por_ni),
    .byte_i       (rx_byte),
    .byte_valid_i (rx_valid),
    .iccm_wr_o    (iccm_wr),
    .iccm_we_o    (iccm_we),
    .q_wdata_o    (q_wdata_o),
    .q_valid_o    (q_valid_o),
    .prog_done_o  (prog_done_o),
    .reset_req_o  (reset_req_o),
    .flash_intf_o (flash_intf_o),
    .target_mem_o (target_mem_o)
  );

  iccm_ram iccm_ram_i (
    .clk_i     (clk_i),
    .we_i      (iccm_we),
    .wr_i      (iccm_wr),
    .rd_addr_i (rd_addr_i),
    .rd_data_o (rd_data_o)
  );

endmodule

// ==== dv/tb_boot_prog.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// Boot programmer testbench, random sessions against a model
// Host sck phases last 4 clk cycles, frame gap is 6 cycles
// Only ICCM words the model holds are read back
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

`include "prog_defs.svh"

module tb_boot_prog;

  // About 600 frames of ~71 cycles, so this leaves a wide margin
  localparam int MaxCycles = 200000;

  logic                clk;
  logic                por_n;
  logic                sck;
  logic                sdi;
  logic                csb;
  logic [`PROG_AW-1:0] rd_addr;
  logic [31:0]         rd_data;
  logic [31:0]         q_wdata;
  logic                q_valid;
  logic                prog_done;
  logic                reset_req;
  logic                flash_intf;
  logic                target_mem;

  logic [31:0] iccm_model [bit [`PROG_AW-1:0]];
  logic        exp_done;
  logic        exp_reset;
  logic        exp_flash;
  logic        exp_target;
  logic [31:0] exp_q_word;
  logic [31:0] q_last;
  int          exp_q_count;
  int          q_count;
  int          frame_count;
  int          cycle_count;

  boot_prog_top boot_prog_top_i (
    .clk_i        (clk),
    .por_ni       (por_n),
    .sck_i        (sck),
    .sdi_i        (sdi),
    .csb_i        (csb),
    .rd_addr_i    (rd_addr),
    .rd_data_o    (rd_data),
    .q_wdata_o    (q_wdata),
    .q_valid_o    (q_valid),
    .prog_done_o  (prog_done),
    .reset_req_o  (reset_req),
    .flash_intf_o (flash_intf),
    .target_mem_o (target_mem)
  );

  always #10 clk = ~clk;

  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= MaxCycles) begin
      $display("Timeout: the run did not finish within %0d clock cycles", MaxCycles);
      $display("CHECKS FAILED");
      $fatal(1, "simulation stopped by the cycle limit");
    end
  end

  // Registered pulse, so one sample per rising edge
  always @(posedge clk) begin
    if (por_n && q_valid) begin
      q_count = q_count + 1;
      q_last  = q_wdata;
    end
  end

  task automatic report_mismatch(input string msg);
    $display("FAIL @ %0t ns: %s", $time, msg);
    $display("CHECKS FAILED");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic check_bit(input string what, input logic got, input logic exp);
    assert (got === exp) else
      report_mismatch($sformatf("%s is %b, expected %b", what, got, exp));
  endtask

  task automatic check_status(input string where);
    check_bit({where, ": prog_done_o"}, prog_done, exp_done);
    check_bit({where, ": reset_req_o"}, reset_req, exp_reset);
    check_bit({where, ": flash_intf_o"}, flash_intf, exp_flash);
    check_bit({where, ": target_mem_o"}, target_mem, exp_target);
    assert (q_count == exp_q_count) else
      report_mismatch($sformatf("%s: %0d q_valid_o pulses, expected %0d",
                                where, q_count, exp_q_count));
    if (exp_q_count > 0) begin
      assert (q_last === exp_q_word) else
        report_mismatch($sformatf("%s: q_wdata_o is %h, expected %h",
                                  where, q_last, exp_q_word));
      // Config word holds until the next QSPI session
      assert (q_wdata === exp_q_word) else
        report_mismatch($sformatf("%s: q_wdata_o holds %h, expected %h",
                                  where, q_wdata, exp_q_word));
    end
  endtask

  task automatic check_readback(input string where);
    foreach (iccm_model[a]) begin
      rd_addr = a;
      @(negedge clk);
      assert (rd_data === iccm_model[a]) else
        report_mismatch($sformatf("%s: ICCM[%0d] is %h, expected %h",
                                  where, a, rd_data, iccm_model[a]));
    end
  endtask

  // One csb frame, LSB first
  task automatic send_byte(input logic [7:0] b);
    @(negedge clk);
    csb = 1'b0;
    for (int i = 0; i < 8; i++) begin
      sdi = b[i];
      sck = 1'b0;
      repeat (4) @(negedge clk);
      sck = 1'b1;
      repeat (4) @(negedge clk);
    end
    sck = 1'b0;
    csb = 1'b1;
    repeat (6) @(negedge clk);
    frame_count++;
  endtask

  task automatic send_word(input logic [31:0] w);
    for (int i = 0; i < 4; i++) begin
      send_byte(w[8*i +: 8]);
    end
  endtask

  function automatic logic [31:0] random_word();
    logic [31:0] w;
    w = $urandom;
    while (w == `PROG_END_WORD) begin
      w = $urandom;
    end
    return w;
  endfunction

  task automatic wait_for_done();
    int waited;
    waited = 0;
    while (!prog_done && waited < 20) begin
      @(negedge clk);
      waited++;
    end
    check_bit("prog_done_o after end word", prog_done, 1'b1);
  endtask

  task automatic iccm_session(input int n);
    logic [31:0] w;
    send_byte(`PROG_CMD_ICCM);
    exp_reset = 1'b1;
    exp_done  = 1'b0;
    check_status("ICCM command");
    for (int i = 0; i < n; i++) begin
      w = random_word();
      send_word(w);
      // Every session starts again at address 0
      iccm_model[i[`PROG_AW-1:0]] = w;
      check_status("ICCM data");
    end
    send_word(`PROG_END_WORD);
    exp_reset  = 1'b0;
    exp_done   = 1'b1;
    exp_target = 1'b0;
    wait_for_done();
    check_status("ICCM end");
    check_readback("ICCM session");
  endtask

  task automatic flash_session(input int n);
    send_byte(`PROG_CMD_FLASH);
    exp_reset = 1'b1;
    exp_done  = 1'b0;
    exp_flash = 1'b1;
    check_status("flash command");
    for (int i = 0; i < n; i++) begin
      send_word(random_word());
      check_status("flash data");
    end
    send_word(`PROG_END_WORD);
    exp_reset  = 1'b0;
    exp_done   = 1'b1;
    exp_flash  = 1'b0;
    exp_target = 1'b1;
    wait_for_done();
    check_status("flash end");
    check_readback("flash session");
  endtask

  task automatic qspi_session();
    logic [31:0] w;
    int          waited;
    w      = $urandom;
    waited = 0;
    send_byte(`PROG_CMD_QSPI);
    check_status("QSPI command");
    send_word(w);
    while (q_count == exp_q_count && waited < 20) begin
      @(negedge clk);
      waited++;
    end
    exp_q_count++;
    exp_q_word = w;
    // A second pulse would be counted by now
    repeat (8) @(negedge clk);
    check_status("QSPI config");
  endtask

  task automatic unknown_command();
    logic [31:0] r;
    r = $urandom;
    while (r[7:0] == `PROG_CMD_ICCM || r[7:0] == `PROG_CMD_FLASH ||
           r[7:0] == `PROG_CMD_QSPI) begin
      r = $urandom;
    end
    send_byte(r[7:0]);
    check_status("unknown command");
  endtask

  initial begin
    int kind;
    clk         = 1'b0;
    por_n       = 1'b0;
    sck         = 1'b0;
    sdi         = 1'b0;
    csb         = 1'b1;
    rd_addr     = '0;
    exp_done    = 1'b1;
    exp_reset   = 1'b0;
    exp_flash   = 1'b0;
    exp_target  = 1'b1;
    exp_q_word  = '0;
    q_last      = '0;
    exp_q_count = 0;
    q_count     = 0;
    frame_count = 0;
    cycle_count = 0;
    void'($urandom(32'h058f_d721));
    repeat (8) @(negedge clk);
    por_n = 1'b1;
    @(negedge clk);
    check_bit("q_valid_o after reset", q_valid, 1'b0);
    check_status("after reset");

    iccm_session($urandom_range(1, 40));
    qspi_session();
    check_readback("after QSPI");
    flash_session($urandom_range(2, 8));
    unknown_command();
    qspi_session();

    // Mixed traffic up to about 600 frames in all
    while (frame_count < 600) begin
      kind = $urandom_range(0, 3);
      case (kind)
        0: iccm_session($urandom_range(1, 12));
        1: flash_session($urandom_range(1, 8));
        2: qspi_session();
        default: unknown_command();
      endcase
      check_readback("mixed traffic");
    end

    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

// ==== sources.f ====
+incdir+hdl
hdl/prog_link_pkg.sv
hdl/prog_mem_pkg.sv
hdl/spi_byte_rx.sv
hdl/boot_prog_ctrl.sv
hdl/iccm_ram.sv
hdl/boot_prog_top.sv
dv/tb_boot_prog.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    = --binary --timing --assert -j 0
LINTFLAGS = --lint-only --timing --assert
TOP       = tb_boot_prog
RTL_TOP   = boot_prog_top
FILELIST  = sources.f
OBJ_DIR   = obj_dir
LOG       = sim.log
FAIL_MSG  = CHECKS FAILED

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation reported a failure"; exit 1; fi
	@grep -q "ALL CHECKS PASSED" $(LOG) || { echo "Simulation ended without a result"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
